/* source/ulpi_pkg.sv */
//////////////////////////////
// ULPI link shared constants
// TXCMD codes, bus widths and the
// field layout of the RX CMD byte
//////////////////////////////

package ulpi_pkg;

    // Bus widths fixed by the ULPI spec
    localparam int addr_w = 6;          // Immediate register address
    localparam int data_w = 8;          // ULPI data bus

    // TXCMD prefix sits in the top two bits of the command byte
    localparam int cmd_w = 2;
    localparam logic [cmd_w-1:0] cmd_reg_write = 2'b10;    // 10aaaaaa
    localparam logic [cmd_w-1:0] cmd_reg_read  = 2'b11;    // 11aaaaaa

    // RX CMD byte layout
    // Every status field is two bits wide
    localparam int rx_field_w = 2;

    // D1..D0 carry the line state
    localparam int linestate_lsb = 0;

    // D3..D2 carry the encoded VBUS level
    localparam int vbus_lsb = 2;

    // D5..D4 carry RxActive / RxError
    localparam int rxevent_lsb = 4;

    // D7..D6 are ID and alt_int, not decoded here

endpackage

/* source/ulpi_reg_read.sv */
//////////////////////////////
// ULPI register read engine
// Sends the read TXCMD, waits out
// the turnaround and captures the
// register byte from the PHY
//////////////////////////////

`timescale 1ns/1ps

module ulpi_reg_read (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,      // One-cycle request from bus_ctrl
    input  logic [ulpi_pkg::addr_w-1:0] addr,       // Held by bus_ctrl
    input  logic                        dir,
    input  logic                        nxt,
    input  logic [ulpi_pkg::data_w-1:0] ulpi_din,   // Bus as seen at the pad
    output logic [ulpi_pkg::data_w-1:0] dout,       // Link-side drive, zero when idle
    output logic [ulpi_pkg::data_w-1:0] data,       // Last register value read
    output logic                        busy,
    output logic                        done
);

    typedef enum logic [1:0] {
        s_idle,
        s_txcmd,
        s_wait,
        s_save
    } state_t;

    state_t state;

    assign busy = (state != s_idle);

    // Done in the first cycle the PHY gives the bus back
    assign done = (state == s_save) && !dir;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            dout  <= '0;
            data  <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_txcmd;
                        dout  <= {ulpi_pkg::cmd_reg_read, addr};  // TXCMD next cycle
                    end
                end
                s_txcmd: begin
                    // PHY stretches the TXCMD until it has latched it
                    if (nxt) begin
                        state <= s_wait;
                        dout  <= '0;        // Release for turnaround
                    end
                end
                s_wait: begin
                    state <= s_save;        // PHY raises dir here
                end
                s_save: begin
                    if (dir) begin
                        data <= ulpi_din;   // Register byte from the PHY
                    end else begin
                        state <= s_idle;    // Bus back with the link
                    end
                end
                default: begin
                    state <= s_idle;
                    dout  <= '0;
                end
            endcase
        end
    end

endmodule

/* source/ulpi_reg_write.sv */
//////////////////////////////
// ULPI register write engine
// Sends the write TXCMD and the
// data byte, then strobes stp
//////////////////////////////

`timescale 1ns/1ps

module ulpi_reg_write (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,      // One-cycle request from bus_ctrl
    input  logic [ulpi_pkg::addr_w-1:0] addr,
    input  logic [ulpi_pkg::data_w-1:0] wdata,      // Held by bus_ctrl for the access
    input  logic                        nxt,
    output logic [ulpi_pkg::data_w-1:0] dout,       // Link-side drive, zero when idle
    output logic                        stp,
    output logic                        busy,
    output logic                        done
);

    typedef enum logic [1:0] {
        s_idle,
        s_txcmd,
        s_data,
        s_stop
    } state_t;

    state_t state;

    assign busy = (state != s_idle);

    // Stop cycle ends the access on both sides
    assign stp  = (state == s_stop);
    assign done = (state == s_stop);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            dout  <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_txcmd;
                        dout  <= {ulpi_pkg::cmd_reg_write, addr};
                    end
                end
                s_txcmd: begin
                    // Command latched, present the data byte
                    if (nxt) begin
                        state <= s_data;
                        dout  <= wdata;
                    end
                end
                s_data: begin
                    // PHY took the data, bus goes quiet with stp
                    if (nxt) begin
                        state <= s_stop;
                        dout  <= '0;
                    end
                end
                s_stop: begin
                    state <= s_idle;        // stp lasts a single cycle
                end
                default: begin
                    state <= s_idle;
                    dout  <= '0;
                end
            endcase
        end
    end

endmodule

/* source/ulpi_rx_cmd.sv */
//////////////////////////////
// ULPI RX CMD capture
// Picks up status bytes the PHY
// sends on its own and splits
// them into fields
//////////////////////////////

`timescale 1ns/1ps

module ulpi_rx_cmd (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            dir,
    input  logic                            nxt,
    input  logic                            rd_busy,    // Turnaround belongs to a read
    input  logic [ulpi_pkg::data_w-1:0]     ulpi_din,
    output logic                            rx_valid,
    output logic [ulpi_pkg::rx_field_w-1:0] linestate,
    output logic [ulpi_pkg::rx_field_w-1:0] vbus_state,
    output logic [ulpi_pkg::rx_field_w-1:0] rx_event
);

    logic dir_q;        // dir one cycle back
    logic rx_active;    // PHY owns the bus for status, not for a read
    logic capture;

    // Turnaround done, nxt low means status byte rather than packet data
    assign capture = rx_active && dir && !nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            dir_q      <= 1'b0;
            rx_active  <= 1'b0;
            rx_valid   <= 1'b0;
            linestate  <= '0;
            vbus_state <= '0;
            rx_event   <= '0;
        end else begin
            dir_q    <= dir;
            rx_valid <= capture;
            if (!dir) begin
                rx_active <= 1'b0;
            end else if (!dir_q && !rd_busy) begin
                rx_active <= 1'b1;      // Rising dir not caused by a read
            end
            if (capture) begin
                linestate  <= ulpi_din[ulpi_pkg::linestate_lsb +: ulpi_pkg::rx_field_w];
                vbus_state <= ulpi_din[ulpi_pkg::vbus_lsb +: ulpi_pkg::rx_field_w];
                rx_event   <= ulpi_din[ulpi_pkg::rxevent_lsb +: ulpi_pkg::rx_field_w];
            end
        end
    end

endmodule

/* source/ulpi_bus_ctrl.sv */
//////////////////////////////
// ULPI bus controller
// Accepts one register access at
// a time, starts the matching
// engine and merges bus drives
//////////////////////////////

`timescale 1ns/1ps

module ulpi_bus_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    // User request
    input  logic                        reg_req,    // Strobe, dropped when not accepted
    input  logic                        reg_we,     // 1 write, 0 read
    input  logic [ulpi_pkg::addr_w-1:0] reg_addr,
    input  logic [ulpi_pkg::data_w-1:0] reg_wdata,
    input  logic                        dir,
    // Engine status
    input  logic                        rd_busy,
    input  logic                        wr_busy,
    input  logic                        rd_done,
    input  logic                        wr_done,
    input  logic [ulpi_pkg::data_w-1:0] rd_dout,
    input  logic [ulpi_pkg::data_w-1:0] wr_dout,
    // To user
    output logic                        busy,
    output logic                        reg_done,
    // To engines
    output logic                        rd_start,
    output logic                        wr_start,
    output logic [ulpi_pkg::addr_w-1:0] acc_addr,
    output logic [ulpi_pkg::data_w-1:0] acc_wdata,
    // To pad
    output logic [ulpi_pkg::data_w-1:0] link_dout
);

    logic accept;
    logic acc_done;

    // Only with the bus idle and owned by the link
    assign accept   = reg_req && !busy && !rd_busy && !wr_busy && !dir;
    assign acc_done = rd_done || wr_done;

    // Idle engines drive zero, so an OR is enough
    assign link_dout = rd_dout | wr_dout;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            reg_done <= 1'b0;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
        end else begin
            rd_start <= accept && !reg_we;      // Exactly one engine per access
            wr_start <= accept && reg_we;
            reg_done <= acc_done;
            if (accept) begin
                busy <= 1'b1;
            end else if (acc_done) begin
                busy <= 1'b0;                   // Falls with reg_done
            end
        end
    end

    // Request payload, held for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_addr  <= reg_addr;
            acc_wdata <= reg_wdata;
        end
    end

endmodule

/* source/ulpi_link.sv */
//////////////////////////////
// ULPI link top
// Register access and RX CMD
// capture over the ULPI pins
//////////////////////////////

`timescale 1ns/1ps

module ulpi_link (
    input  logic                            clk,
    input  logic                            rst,
    // Register access port
    input  logic                            reg_req,
    input  logic                            reg_we,
    input  logic [ulpi_pkg::addr_w-1:0]     reg_addr,
    input  logic [ulpi_pkg::data_w-1:0]     reg_wdata,
    output logic                            busy,
    output logic                            reg_done,
    output logic [ulpi_pkg::data_w-1:0]     reg_rdata,
    // PHY status
    output logic                            rx_valid,
    output logic [ulpi_pkg::rx_field_w-1:0] linestate,
    output logic [ulpi_pkg::rx_field_w-1:0] vbus_state,
    output logic [ulpi_pkg::rx_field_w-1:0] rx_event,
    // ULPI pins
    input  logic                            dir,
    input  logic                            nxt,
    output logic                            stp,
    inout  wire  [ulpi_pkg::data_w-1:0]     ulpi_data
);

    logic                        rd_start, wr_start;
    logic                        rd_busy, wr_busy;
    logic                        rd_done, wr_done;
    logic [ulpi_pkg::data_w-1:0] rd_dout, wr_dout;
    logic [ulpi_pkg::addr_w-1:0] acc_addr;
    logic [ulpi_pkg::data_w-1:0] acc_wdata;
    logic [ulpi_pkg::data_w-1:0] link_dout;

    // PHY owns the bus whenever dir is high
    assign ulpi_data = dir ? 'z : link_dout;

    ulpi_bus_ctrl u_bus_ctrl (
        .clk(clk), .rst(rst),
        .reg_req(reg_req), .reg_we(reg_we), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .dir(dir),
        .rd_busy(rd_busy), .wr_busy(wr_busy), .rd_done(rd_done), .wr_done(wr_done),
        .rd_dout(rd_dout), .wr_dout(wr_dout),
        .busy(busy), .reg_done(reg_done),
        .rd_start(rd_start), .wr_start(wr_start),
        .acc_addr(acc_addr), .acc_wdata(acc_wdata),
        .link_dout(link_dout)
    );

    ulpi_reg_read u_reg_read (
        .clk(clk), .rst(rst),
        .start(rd_start), .addr(acc_addr),
        .dir(dir), .nxt(nxt), .ulpi_din(ulpi_data),
        .dout(rd_dout), .data(reg_rdata),   // Read data straight to the user
        .busy(rd_busy), .done(rd_done)
    );

    ulpi_reg_write u_reg_write (
        .clk(clk), .rst(rst),
        .start(wr_start), .addr(acc_addr), .wdata(acc_wdata),
        .nxt(nxt),
        .dout(wr_dout), .stp(stp),
        .busy(wr_busy), .done(wr_done)
    );

    ulpi_rx_cmd u_rx_cmd (
        .clk(clk), .rst(rst),
        .dir(dir), .nxt(nxt), .rd_busy(rd_busy), .ulpi_din(ulpi_data),
        .rx_valid(rx_valid),
        .linestate(linestate), .vbus_state(vbus_state), .rx_event(rx_event)
    );

endmodule

/* verif/ulpi_phy_model.sv */
//////////////////////////////
// Behavioural ULPI PHY
// Register file, programmable
// NXT delay, RX CMD injection
//////////////////////////////

`timescale 1ns/1ps

module ulpi_phy_model (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stp,
    input  logic [3:0]                  nxt_delay,  // Cycles before nxt answers a byte
    input  logic                        rx_req,     // One-cycle request to send rx_byte
    input  logic [ulpi_pkg::data_w-1:0] rx_byte,
    output logic                        dir,
    output logic                        nxt,
    inout  wire  [ulpi_pkg::data_w-1:0] ulpi_data
);

    logic [ulpi_pkg::data_w-1:0] regs [64];     // Immediate register space
    logic [ulpi_pkg::data_w-1:0] drive;
    logic                        drive_en;
    logic                        rx_pending;
    logic [ulpi_pkg::data_w-1:0] rx_hold;
    int                          access_count;  // Completed register accesses

    assign ulpi_data = drive_en ? drive : 'z;

    // Power-on contents, register a holds {a[1:0], a} ^ 8'ha5
    function automatic logic [7:0] reset_value(input logic [5:0] a);
        return {a[1:0], a} ^ 8'ha5;
    endfunction

    // Entered on an edge, returns on the edge where the link samples nxt high
    task automatic ack_after_delay();
        #1;
        if (nxt_delay == 0) begin
            nxt = 1'b1;
        end else begin
            nxt = 1'b0;
            repeat (nxt_delay) @(posedge clk);
            #1 nxt = 1'b1;
        end
        @(posedge clk);
    endtask

    task automatic reg_read(input logic [5:0] a);
        ack_after_delay();
        #1;
        nxt = 1'b0;
        dir = 1'b1;                 // Turnaround
        @(posedge clk);
        #1;
        drive    = regs[a];         // Single data cycle
        drive_en = 1'b1;
        @(posedge clk);
        #1;
        dir      = 1'b0;            // Bus back to the link
        drive_en = 1'b0;
        access_count++;
    endtask

    task automatic reg_write(input logic [5:0] a);
        logic [7:0] d;
        ack_after_delay();          // TXCMD taken
        ack_after_delay();
        d = ulpi_data;              // Data byte as the link saw nxt
        #1 nxt = 1'b0;
        @(posedge clk);
        if (stp) begin
            regs[a] = d;            // Committed only on stp
        end
        access_count++;
    endtask

    task automatic send_rx_cmd(input logic [7:0] b);
        #1 dir = 1'b1;
        @(posedge clk);
        #1;
        drive    = b;
        drive_en = 1'b1;
        @(posedge clk);
        #1;
        dir      = 1'b0;
        drive_en = 1'b0;
    endtask

    initial begin
        dir          = 1'b0;
        nxt          = 1'b0;
        drive        = '0;
        drive_en     = 1'b0;
        rx_pending   = 1'b0;
        rx_hold      = '0;
        access_count = 0;
        for (int i = 0; i < 64; i++) begin
            regs[i] = reset_value(i[5:0]);
        end
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (rx_req) begin
                    rx_pending = 1'b1;
                    rx_hold    = rx_byte;
                end
                if (!dir && ulpi_data[7:6] == ulpi_pkg::cmd_reg_read) begin
                    reg_read(ulpi_data[5:0]);
                end else if (!dir && ulpi_data[7:6] == ulpi_pkg::cmd_reg_write) begin
                    reg_write(ulpi_data[5:0]);
                end else if (rx_pending) begin
                    rx_pending = 1'b0;      // Bus idle, status goes out now
                    send_rx_cmd(rx_hold);
                end
            end
        end
    end

endmodule

/* verif/tb_ulpi_link.sv */
//////////////////////////////
// ULPI link testbench
// Directed register and RX CMD
// tests against a PHY model
//////////////////////////////

`timescale 1ns/1ps

module tb_ulpi_link;

    localparam int max_cycles = 4000;   // Tests take about 1100 cycles, plus margin
    localparam int done_wait  = 100;    // Far above one access with nxt delay 5

    logic       clk = 1'b0;
    logic       rst;
    logic       reg_req, reg_we;
    logic [5:0] reg_addr;
    logic [7:0] reg_wdata, reg_rdata, rx_byte;
    logic       busy, reg_done, rx_valid, stp, dir, nxt, rx_req;
    logic [1:0] linestate, vbus_state, rx_event;
    logic [3:0] nxt_delay;
    wire  [7:0] ulpi_data;

    int          errors, test_errors, cycles, stp_cycles, rx_pulses, done_pulses, latency;
    string       test_name;
    logic [31:0] lfsr;
    logic [7:0]  shadow [64];       // Expected PHY register contents

    always #4 clk = ~clk;

    ulpi_link u_dut (
        .clk(clk), .rst(rst),
        .reg_req(reg_req), .reg_we(reg_we), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .busy(busy), .reg_done(reg_done), .reg_rdata(reg_rdata),
        .rx_valid(rx_valid), .linestate(linestate), .vbus_state(vbus_state),
        .rx_event(rx_event),
        .dir(dir), .nxt(nxt), .stp(stp), .ulpi_data(ulpi_data)
    );

    ulpi_phy_model u_phy (
        .clk(clk), .rst(rst), .stp(stp), .nxt_delay(nxt_delay),
        .rx_req(rx_req), .rx_byte(rx_byte),
        .dir(dir), .nxt(nxt), .ulpi_data(ulpi_data)
    );

    // Pulse counters and run limit
    always @(posedge clk) begin
        cycles++;
        if (stp) stp_cycles++;
        if (rx_valid) rx_pulses++;
        if (reg_done) done_pulses++;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, the run was stopped", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // Documented power-on register contents of the PHY
    function automatic logic [7:0] reset_value(input logic [5:0] a);
        return {a[1:0], a} ^ 8'ha5;
    endfunction

    // Galois LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Error in %s (%s): expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        $display("Test %s finished with %0d errors", test_name, errors - test_errors);
    endtask

    // Ends 1 ns after the edge where reg_done was seen
    task automatic wait_done(output int n, output int nxt_at);
        logic seen;
        n      = 0;
        nxt_at = -1;
        seen   = 1'b0;
        while (!seen && n < done_wait) begin
            @(posedge clk);
            n++;
            if (nxt && nxt_at < 0) nxt_at = n;
            seen = reg_done;
        end
        #1;
        if (!seen) begin
            errors++;
            $display("No reg_done within %0d cycles in test %s", done_wait, test_name);
        end
    endtask

    task automatic access(input logic we, input logic [5:0] addr, input logic [7:0] wdata,
                          output logic [7:0] rdata);
        int n;
        int nxt_at;
        int pulses;
        pulses    = done_pulses;
        reg_req   = 1'b1;
        reg_we    = we;
        reg_addr  = addr;
        reg_wdata = wdata;
        @(posedge clk);
        #1 reg_req = 1'b0;
        wait_done(n, nxt_at);
        latency = n - nxt_at;       // Edges from nxt seen high to reg_done seen high
        rdata   = reg_rdata;
        @(posedge clk);             // Room for an unwanted second pulse
        #1;
        check("reg_done pulses", 1, done_pulses - pulses);
        check("busy after done", 0, 32'(busy));
    endtask

    task automatic read_reset_values();
        logic [7:0] rd;
        begin_test("reset_values");
        check("idle outputs", 0, 32'({busy, reg_done, rx_valid, stp}));
        check("idle fields", 0, 32'({linestate, vbus_state, rx_event}));
        check("link bus drive", 0, 32'(ulpi_data));
        for (int a = 0; a < 64; a += 9) begin
            access(1'b0, a[5:0], 8'h00, rd);
            check("reset value", 32'(reset_value(a[5:0])), 32'(rd));
        end
        end_test();
    endtask

    task automatic write_read_back();
        logic [7:0] rd;
        logic [7:0] d;
        logic [5:0] a;
        int         s;
        begin_test("write_read");
        for (int i = 0; i < 4; i++) begin
            a = 6'(i * 17 + 3);
            d = 8'(8'h5a + i * 8'h31);
            s = stp_cycles;
            access(1'b1, a, d, rd);
            check("stp cycles", 1, stp_cycles - s);
            check("model register", 32'(d), 32'(u_phy.regs[a]));
            shadow[a] = d;
            access(1'b0, a, 8'h00, rd);
            check("read back", 32'(d), 32'(rd));
        end
        end_test();
    endtask

    task automatic sweep_nxt_delay();
        logic [7:0] rd;
        logic [5:0] a;
        begin_test("nxt_delay");
        for (int dly = 0; dly <= 5; dly++) begin
            nxt_delay = dly[3:0];
            a         = 6'(dly * 7 + 2);
            access(1'b0, a, 8'h00, rd);
            check("read data", 32'(shadow[a]), 32'(rd));
            check("nxt to reg_done", 3 + 1, latency);   // Engine 3, bus_ctrl register 1
        end
        nxt_delay = '0;
        end_test();
    endtask

    task automatic drop_busy_strobe();
        int n;
        int nxt_at;
        int count;
        int pulses;
        begin_test("busy_drop");
        count     = u_phy.access_count;
        nxt_delay = 4'd2;
        reg_req   = 1'b1;
        reg_we    = 1'b1;
        reg_addr  = 6'h11;
        reg_wdata = 8'hc3;
        @(posedge clk);
        #1 reg_req = 1'b0;
        @(posedge clk);
        #1;
        check("busy during access", 1, 32'(busy));
        reg_req   = 1'b1;           // Second strobe, must be dropped
        reg_addr  = 6'h22;
        reg_wdata = 8'h3c;
        @(posedge clk);
        #1 reg_req = 1'b0;
        wait_done(n, nxt_at);
        pulses = done_pulses;
        repeat (done_wait) @(posedge clk);  // A queued second write would end in here
        #1;
        check("reg_done after drop", 0, done_pulses - pulses);
        check("accesses seen by PHY", 1, u_phy.access_count - count);
        check("first register", 32'h000000c3, 32'(u_phy.regs[6'h11]));
        check("dropped register", 32'(shadow[6'h22]), 32'(u_phy.regs[6'h22]));
        shadow[6'h11] = 8'hc3;
        nxt_delay     = '0;
        end_test();
    endtask

    task automatic capture_rx_cmd();
        logic [7:0] b;
        logic [7:0] rd;
        logic       seen;
        int         p;
        int         n;
        begin_test("rx_cmd");
        for (int i = 0; i < 2; i++) begin
            b       = (i == 0) ? 8'h2d : 8'h96;
            p       = rx_pulses;
            rx_byte = b;
            rx_req  = 1'b1;
            @(posedge clk);
            #1 rx_req = 1'b0;
            n    = 0;
            seen = 1'b0;
            while (!seen && n < 20) begin
                @(posedge clk);
                n++;
                seen = rx_valid;
            end
            @(posedge clk);
            #1;
            if (!seen) begin
                errors++;
                $display("No rx_valid after RX CMD %0h in test %s", b, test_name);
            end
            check("rx_valid pulses", 1, rx_pulses - p);
            check("linestate", 32'(b[ulpi_pkg::linestate_lsb +: 2]), 32'(linestate));
            check("vbus_state", 32'(b[ulpi_pkg::vbus_lsb +: 2]), 32'(vbus_state));
            check("rx_event", 32'(b[ulpi_pkg::rxevent_lsb +: 2]), 32'(rx_event));
        end
        p = rx_pulses;              // Read turnaround is not an RX CMD
        access(1'b0, 6'h05, 8'h00, rd);
        check("rx_valid during read", 0, rx_pulses - p);
        check("read data", 32'(shadow[6'h05]), 32'(rd));
        check("linestate held", 32'(b[ulpi_pkg::linestate_lsb +: 2]), 32'(linestate));
        end_test();
    endtask

    task automatic random_accesses();
        logic       we;
        logic [5:0] a;
        logic [7:0] d;
        logic [7:0] rd;
        begin_test("random");
        for (int i = 0; i < 50; i++) begin
            we        = 1'(take_bits(1));
            a         = 6'(take_bits(6));
            d         = 8'(take_bits(8));
            nxt_delay = 4'(take_bits(3) % 6);
            access(we, a, d, rd);
            if (we) begin
                shadow[a] = d;
                check("model register", 32'(d), 32'(u_phy.regs[a]));
            end else begin
                check("read data", 32'(shadow[a]), 32'(rd));
            end
        end
        nxt_delay = '0;
        end_test();
    endtask

    initial begin
        rst         = 1'b1;
        reg_req     = 1'b0;
        reg_we      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        nxt_delay   = '0;
        rx_req      = 1'b0;
        rx_byte     = '0;
        errors      = 0;
        test_errors = 0;
        cycles      = 0;
        stp_cycles  = 0;
        rx_pulses   = 0;
        done_pulses = 0;
        latency     = 0;
        lfsr        = 32'hbadf711f;
        for (int a = 0; a < 64; a++) begin
            shadow[a] = reset_value(a[5:0]);
        end
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        #1;
        read_reset_values();
        write_read_back();
        sweep_nxt_delay();
        drop_busy_strobe();
        capture_rx_cmd();
        random_accesses();
        $display("All tests done: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* build.f */
source/ulpi_pkg.sv
source/ulpi_reg_read.sv
source/ulpi_reg_write.sv
source/ulpi_rx_cmd.sv
source/ulpi_bus_ctrl.sv
source/ulpi_link.sv
verif/ulpi_phy_model.sv
verif/tb_ulpi_link.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the ULPI link testbench with Verilator, log in sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module tb_ulpi_link -o sim_tb > sim.log 2>&1 \
    && ./obj_dir/sim_tb >> sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see sim.log"; exit 1; }
grep -q "Something failed" sim.log \
    && { echo "Simulation failed, see sim.log"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
